//--- build.f
+incdir+tb
src/rv_core_pkg.sv
src/bundle_if.sv
src/fetch_unit.sv
src/inst_buffer.sv
src/lane_decoder.sv
src/issue_execute.sv
src/reg_file.sv
src/perf_counters.sv
src/rv_superscalar_core.sv
tb/tb_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary -Wno-fatal --top-module tb_core -Mdir obj_dir -f build.f > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_core > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Test OK" sim.log && echo "Simulation passed" \
    || { echo "Simulation ended without a result"; exit 1; }

//--- tb/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ==============================
// RV32I encoders
// ==============================

localparam logic [6:0] OPC_REG = 7'b0110011;
localparam logic [6:0] OPC_IMM = 7'b0010011;

// Register-register form
function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                       input int rd, input int rs1, input int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_REG};
endfunction

// Register-immediate form, imm truncated to 12 bits
function automatic logic [31:0] i_type(input logic [2:0] f3, input int rd,
                                       input int rs1, input int imm);
    return {12'(imm), 5'(rs1), f3, 5'(rd), OPC_IMM};
endfunction

function automatic logic [31:0] add_instr(input int rd, input int rs1, input int rs2);
    return r_type(7'h00, 3'b000, rd, rs1, rs2);
endfunction

function automatic logic [31:0] sub_instr(input int rd, input int rs1, input int rs2);
    return r_type(7'h20, 3'b000, rd, rs1, rs2);
endfunction

function automatic logic [31:0] and_instr(input int rd, input int rs1, input int rs2);
    return r_type(7'h00, 3'b111, rd, rs1, rs2);
endfunction

function automatic logic [31:0] or_instr(input int rd, input int rs1, input int rs2);
    return r_type(7'h00, 3'b110, rd, rs1, rs2);
endfunction

function automatic logic [31:0] xor_instr(input int rd, input int rs1, input int rs2);
    return r_type(7'h00, 3'b100, rd, rs1, rs2);
endfunction

function automatic logic [31:0] addi_instr(input int rd, input int rs1, input int imm);
    return i_type(3'b000, rd, rs1, imm);
endfunction

function automatic logic [31:0] andi_instr(input int rd, input int rs1, input int imm);
    return i_type(3'b111, rd, rs1, imm);
endfunction

function automatic logic [31:0] ori_instr(input int rd, input int rs1, input int imm);
    return i_type(3'b110, rd, rs1, imm);
endfunction

function automatic logic [31:0] xori_instr(input int rd, input int rs1, input int imm);
    return i_type(3'b100, rd, rs1, imm);
endfunction

// ==============================
// Reference register file
// ==============================

// Committed architectural state, x0 never written
logic [31:0] model_regs [32];

function automatic void reset_model();
    for (int r = 0; r < 32; r++) begin
        model_regs[r] = '0;
    end
endfunction

// Runs one bundle lane by lane, as a scalar core would
function automatic void exec_bundle(input  logic [2:0][31:0] words,
                                    output logic [2:0]       exp_we,
                                    output logic [2:0][4:0]  exp_rd,
                                    output logic [2:0][31:0] exp_data);
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic        ok;
    for (int l = 0; l < 3; l++) begin
        w   = words[l];
        a   = model_regs[w[19:15]];
        b   = model_regs[w[24:20]];
        imm = {{20{w[31]}}, w[31:20]};
        ok  = 1'b1;
        exp_data[l] = '0;
        if (w[6:0] == OPC_REG && w[31:25] == 7'h00) begin
            case (w[14:12])
                3'b000:  exp_data[l] = a + b;
                3'b100:  exp_data[l] = a ^ b;
                3'b110:  exp_data[l] = a | b;
                3'b111:  exp_data[l] = a & b;
                default: ok = 1'b0;
            endcase
        end else if (w[6:0] == OPC_REG && w[31:25] == 7'h20 && w[14:12] == 3'b000) begin
            exp_data[l] = a - b;
        end else if (w[6:0] == OPC_IMM) begin
            case (w[14:12])
                3'b000:  exp_data[l] = a + imm;
                3'b100:  exp_data[l] = a ^ imm;
                3'b110:  exp_data[l] = a | imm;
                3'b111:  exp_data[l] = a & imm;
                default: ok = 1'b0;
            endcase
        end else begin
            ok = 1'b0;
        end
        exp_rd[l] = w[11:7];
        // No write for unsupported words or rd x0
        exp_we[l] = ok && (w[11:7] != 5'd0);
        if (exp_we[l]) begin
            model_regs[w[11:7]] = exp_data[l];
        end
    end
endfunction

`endif

//--- tb/tb_core.sv
`timescale 1ns/1ps

module tb_core;

    localparam int          BUFFER_DEPTH  = 4;
    localparam int          DIRECTED      = 7;
    localparam int          PROG_BUNDLES  = 27;
    localparam int          PROG_WORDS    = 3 * PROG_BUNDLES;
    localparam int          MEM_WORDS     = 128;
    localparam int          IDX_W         = $clog2(MEM_WORDS);
    localparam int          TOTAL_BUNDLES = PROG_BUNDLES + 2;
    localparam int          CYCLE_LIMIT   = 20 * TOTAL_BUNDLES + 200;
    localparam logic [31:0] PROG_BYTES    = 32'(4 * PROG_WORDS);
    // ADDI x0,x0,0
    localparam logic [31:0] NOP_WORD      = 32'h0000_0013;
    localparam logic [31:0] SEED          = 32'hd0587d1d;

    logic                          clk = 1'b0;
    logic                          reset;
    logic                          stall;
    logic [31:0]                   inst_addr [3];
    logic [31:0]                   inst_data [3];
    logic                          retire_valid;
    logic                          retire_we [3];
    logic [4:0]                    retire_rd [3];
    logic [31:0]                   retire_data [3];
    logic [31:0]                   retire_pc;
    logic [4:0]                    dbg_addr;
    logic [31:0]                   dbg_data;
    logic [31:0]                   perf_cycles;
    logic [31:0]                   perf_fetched;
    logic [31:0]                   perf_executed;
    logic [31:0]                   perf_stalls;
    logic [$clog2(BUFFER_DEPTH):0] occupancy;

    logic [31:0] prog_mem [MEM_WORDS];
    int          cycle_count  = 0;
    int          edges        = 0;
    int          pushes       = 0;
    int          distinct_pcs = 0;
    int          checked      = 0;
    int          retired      = 0;
    logic [31:0] last_push_pc = '0;

    `include "tb_ref_model.svh"

    rv_superscalar_core #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) DUT (
        .clk                  (clk),
        .reset                (reset),
        .inst_addr_o          (inst_addr),
        .inst_data_i          (inst_data),
        .stall_i              (stall),
        .retire_valid_o       (retire_valid),
        .retire_we_o          (retire_we),
        .retire_rd_o          (retire_rd),
        .retire_data_o        (retire_data),
        .retire_pc_o          (retire_pc),
        .dbg_reg_addr_i       (dbg_addr),
        .dbg_reg_data_o       (dbg_data),
        .perf_cycles_o        (perf_cycles),
        .perf_fetched_o       (perf_fetched),
        .perf_executed_o      (perf_executed),
        .perf_buffer_stalls_o (perf_stalls),
        .buffer_occupancy_o   (occupancy)
    );

    always #4 clk = ~clk;

    // Instruction memory returns NOP past the program
    for (genvar g = 0; g < 3; g++) begin : g_imem
        assign inst_data[g] = (inst_addr[g] < PROG_BYTES) ? prog_mem[inst_addr[g][IDX_W+1:2]]
                                                          : NOP_WORD;
    end

    // ==============================
    // Helpers
    // ==============================

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        if (addr < PROG_BYTES) begin
            return prog_mem[addr[IDX_W+1:2]];
        end
        return NOP_WORD;
    endfunction

    // Mixed ALU ops with shifts as the odd unsupported word
    function automatic logic [31:0] random_instr();
        int kind;
        int rd;
        int rs1;
        int rs2;
        int imm;
        kind = int'($urandom % 10);
        rd   = int'($urandom % 16);
        rs1  = int'($urandom % 16);
        rs2  = int'($urandom % 16);
        imm  = int'($urandom % 4096);
        case (kind)
            0:       return add_instr(rd, rs1, rs2);
            1:       return sub_instr(rd, rs1, rs2);
            2:       return and_instr(rd, rs1, rs2);
            3:       return or_instr(rd, rs1, rs2);
            4:       return xor_instr(rd, rs1, rs2);
            5:       return addi_instr(rd, rs1, imm);
            6:       return andi_instr(rd, rs1, imm);
            7:       return ori_instr(rd, rs1, imm);
            8:       return xori_instr(rd, rs1, imm);
            default: return r_type(7'h00, 3'b001, rd, rs1, rs2);
        endcase
    endfunction

    task automatic load_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog_mem[i] = NOP_WORD;
        end
        // Independent immediates
        prog_mem[0]  = addi_instr(1, 0, 100);
        prog_mem[1]  = ori_instr(2, 0, 'h0f0);
        prog_mem[2]  = xori_instr(3, 0, -1);
        // Chain lane 0 to 1 to 2
        prog_mem[3]  = add_instr(4, 1, 2);
        prog_mem[4]  = sub_instr(5, 4, 3);
        prog_mem[5]  = add_instr(6, 5, 4);
        // Same rd in every lane
        prog_mem[6]  = addi_instr(7, 0, 5);
        prog_mem[7]  = addi_instr(7, 7, 6);
        prog_mem[8]  = xori_instr(7, 7, 'h3c);
        // Operands from earlier bundles
        prog_mem[9]  = and_instr(8, 4, 5);
        prog_mem[10] = or_instr(9, 7, 1);
        prog_mem[11] = xor_instr(10, 8, 9);
        // x0 targets, then an x0 operand
        prog_mem[12] = addi_instr(0, 1, 55);
        prog_mem[13] = add_instr(0, 2, 3);
        prog_mem[14] = add_instr(11, 0, 1);
        // Load, bad funct7, shift immediate
        prog_mem[15] = 32'h0000_a083;
        prog_mem[16] = r_type(7'h20, 3'b100, 2, 1, 2);
        prog_mem[17] = i_type(3'b001, 3, 1, 1);
        // Negative immediates
        prog_mem[18] = andi_instr(12, 3, 'h7ff);
        prog_mem[19] = ori_instr(13, 12, -16);
        prog_mem[20] = sub_instr(14, 13, 1);
        for (int i = 3 * DIRECTED; i < PROG_WORDS; i++) begin
            prog_mem[i] = random_instr();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Issue until the given number of bundles has retired, then freeze
    task automatic run_until(input int target);
        next_cycle();
        stall = 1'b0;
        while (retired < target) begin
            next_cycle();
            if (retire_valid) begin
                retired++;
            end
        end
        stall = 1'b1;
    endtask

    // Buffer full and last retire seen by the checker
    task automatic wait_full();
        next_cycle();
        while (int'(occupancy) != BUFFER_DEPTH) begin
            next_cycle();
        end
        repeat (2) next_cycle();
    endtask

    task automatic read_reg(input int idx, output logic [31:0] value);
        next_cycle();
        dbg_addr = 5'(idx);
        #1;
        value = dbg_data;
    endtask

    task automatic sweep_regs(input string name);
        logic [31:0] value;
        for (int r = 0; r < 32; r++) begin
            read_reg(r, value);
            check_value($sformatf("%s x%0d", name, r), model_regs[r], value);
        end
    endtask

    // ==============================
    // Monitors
    // ==============================

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (reset) begin
            edges <= edges + 1;
        end
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, retire stream never completed", CYCLE_LIMIT);
            $display("Test FAILED");
            $fatal(1, "Simulation timed out");
        end
    end

    // Not full at this point means a push at the next edge
    always @(negedge clk) begin
        if (reset && int'(occupancy) != BUFFER_DEPTH) begin
            if (pushes == 0 || inst_addr[0] != last_push_pc) begin
                distinct_pcs++;
            end
            last_push_pc = inst_addr[0];
            pushes++;
        end
    end

    // Retire checker in program order
    always @(negedge clk) begin
        logic [2:0][31:0] words;
        logic [2:0]       exp_we;
        logic [2:0][4:0]  exp_rd;
        logic [2:0][31:0] exp_data;
        logic [31:0]      pc;
        if (reset && retire_valid) begin
            pc = 32'(12 * checked);
            check_value($sformatf("bundle %0d pc", checked), pc, retire_pc);
            for (int l = 0; l < 3; l++) begin
                words[l] = word_at(pc + 32'(4 * l));
            end
            exec_bundle(words, exp_we, exp_rd, exp_data);
            for (int l = 0; l < 3; l++) begin
                check_value($sformatf("bundle %0d lane %0d we", checked, l),
                            32'(exp_we[l]), 32'(retire_we[l]));
                if (exp_we[l]) begin
                    check_value($sformatf("bundle %0d lane %0d rd", checked, l),
                                32'(exp_rd[l]), 32'(retire_rd[l]));
                    check_value($sformatf("bundle %0d lane %0d data", checked, l),
                                exp_data[l], retire_data[l]);
                end
            end
            checked++;
        end
    end

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        int          hold;
        int          max_occ;
        logic [31:0] stalls_before;
        logic [31:0] value;
        reset    = 1'b0;
        stall    = 1'b1;
        dbg_addr = '0;
        void'($urandom(SEED));
        reset_model();
        load_program();
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b1;

        // Directed bundles, then literal register values
        run_until(DIRECTED);
        wait_full();
        read_reg(1, value);
        check_value("addi_x1", 32'd100, value);
        read_reg(2, value);
        check_value("ori_x2", 32'h0000_00f0, value);
        read_reg(3, value);
        check_value("xori_x3", 32'hffff_ffff, value);
        read_reg(7, value);
        check_value("same_rd_x7", 32'd55, value);
        read_reg(11, value);
        check_value("x0_operand_x11", 32'd100, value);
        read_reg(0, value);
        check_value("x0_reads_zero", 32'd0, value);
        sweep_regs("directed_regs");

        // Back-pressure in the middle of the program
        run_until(12);
        stalls_before = perf_stalls;
        hold          = 10 + int'($urandom % 21);
        max_occ       = 0;
        repeat (hold) begin
            next_cycle();
            if (int'(occupancy) > max_occ) begin
                max_occ = int'(occupancy);
            end
        end
        check_value("occupancy_reaches_depth", 32'(BUFFER_DEPTH), 32'(max_occ));
        check_value("buffer_stalls_grow", 32'd1, 32'(perf_stalls > stalls_before));

        // Rest of the program, then counters at quiescence
        run_until(TOTAL_BUNDLES);
        wait_full();
        check_value("fetched_count", 32'(3 * pushes), perf_fetched);
        check_value("executed_count", 32'(3 * checked), perf_executed);
        check_value("pushes_vs_distinct_pcs", 32'(distinct_pcs), 32'(pushes));
        check_value("fetch_pc_vs_pushes", 32'(12 * pushes), inst_addr[0]);
        next_cycle();
        check_value("cycle_count", 32'(edges), perf_cycles);
        sweep_regs("final_regs");

        $display("Test OK");
        $finish;
    end

endmodule

//--- src/rv_superscalar_core.sv
`timescale 1ns/1ps

module rv_superscalar_core import rv_core_pkg::*; #(
    parameter int BUFFER_DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    output word_t                         inst_addr_o [NUM_LANES],
    input  word_t                         inst_data_i [NUM_LANES],
    input  logic                          stall_i,
    output logic                          retire_valid_o,
    output logic                          retire_we_o [NUM_LANES],
    output reg_idx_t                      retire_rd_o [NUM_LANES],
    output word_t                         retire_data_o [NUM_LANES],
    output word_t                         retire_pc_o,
    input  reg_idx_t                      dbg_reg_addr_i,
    output word_t                         dbg_reg_data_o,
    output word_t                         perf_cycles_o,
    output word_t                         perf_fetched_o,
    output word_t                         perf_executed_o,
    output word_t                         perf_buffer_stalls_o,
    output logic [$clog2(BUFFER_DEPTH):0] buffer_occupancy_o
);

    // Register file ports
    reg_idx_t rs_addr [2*NUM_LANES];
    word_t    rs_data [2*NUM_LANES];
    logic     wr_en [NUM_LANES];
    reg_idx_t wr_addr [NUM_LANES];
    word_t    wr_data [NUM_LANES];

    // Fetch to buffer, buffer to issue
    bundle_if fetch_to_buf ();
    bundle_if buf_to_issue ();

    // ==============================
    // Front end
    // ==============================

    fetch_unit u_fetch (
        .clk         (clk),
        .reset       (reset),
        .inst_addr_o (inst_addr_o),
        .inst_data_i (inst_data_i),
        .out         (fetch_to_buf.producer)
    );

    inst_buffer #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) u_buffer (
        .clk         (clk),
        .reset       (reset),
        .in          (fetch_to_buf.consumer),
        .out         (buf_to_issue.producer),
        .occupancy_o (buffer_occupancy_o)
    );

    // ==============================
    // Execute and writeback
    // ==============================

    issue_execute u_issue (
        .clk            (clk),
        .reset          (reset),
        .stall_i        (stall_i),
        .in             (buf_to_issue.consumer),
        .rs_addr_o      (rs_addr),
        .rs_data_i      (rs_data),
        .wr_en_o        (wr_en),
        .wr_addr_o      (wr_addr),
        .wr_data_o      (wr_data),
        .retire_valid_o (retire_valid_o),
        .retire_we_o    (retire_we_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o),
        .retire_pc_o    (retire_pc_o)
    );

    reg_file u_regs (
        .clk        (clk),
        .reset      (reset),
        .rd_addr_i  (rs_addr),
        .rd_data_o  (rs_data),
        .wr_en_i    (wr_en),
        .wr_addr_i  (wr_addr),
        .wr_data_i  (wr_data),
        .dbg_addr_i (dbg_reg_addr_i),
        .dbg_data_o (dbg_reg_data_o)
    );

    // Push is the buffer accept strobe
    perf_counters u_perf (
        .clk             (clk),
        .reset           (reset),
        .push_i          (fetch_to_buf.pop),
        .pop_i           (buf_to_issue.pop),
        .full_i          (fetch_to_buf.full),
        .cycles_o        (perf_cycles_o),
        .fetched_o       (perf_fetched_o),
        .executed_o      (perf_executed_o),
        .buffer_stalls_o (perf_buffer_stalls_o)
    );

endmodule

//--- src/perf_counters.sv
`timescale 1ns/1ps

module perf_counters import rv_core_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  push_i,
    input  logic  pop_i,
    input  logic  full_i,
    output word_t cycles_o,
    output word_t fetched_o,
    output word_t executed_o,
    output word_t buffer_stalls_o
);

    // Instructions per bundle
    localparam word_t LANE_INC = word_t'(NUM_LANES);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            cycles_o        <= '0;
            fetched_o       <= '0;
            executed_o      <= '0;
            buffer_stalls_o <= '0;
        end else begin
            cycles_o <= cycles_o + 1'b1;
            // Whole bundles enter the buffer
            if (push_i) begin
                fetched_o <= fetched_o + LANE_INC;
            end
            // Whole bundles retire together
            if (pop_i) begin
                executed_o <= executed_o + LANE_INC;
            end
            // Fetch held off this cycle
            if (full_i) begin
                buffer_stalls_o <= buffer_stalls_o + 1'b1;
            end
        end
    end

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rd_addr_i [2*NUM_LANES],
    output word_t    rd_data_o [2*NUM_LANES],
    input  logic     wr_en_i [NUM_LANES],
    input  reg_idx_t wr_addr_i [NUM_LANES],
    input  word_t    wr_data_i [NUM_LANES],
    input  reg_idx_t dbg_addr_i,
    output word_t    dbg_data_o
);

    localparam int NUM_REGS = 2**REG_ADDR_W;

    // x1 to x31, x0 has no storage
    word_t regs [1:NUM_REGS-1];

    // Combinational read ports
    always_comb begin
        for (int k = 0; k < 2*NUM_LANES; k++) begin
            rd_data_o[k] = (rd_addr_i[k] == '0) ? '0 : regs[rd_addr_i[k]];
        end
    end

    // Debug port
    assign dbg_data_o = (dbg_addr_i == '0) ? '0 : regs[dbg_addr_i];

    // Three write ports
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int r = 1; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // Highest lane last, so it wins on equal rd
            for (int l = 0; l < NUM_LANES; l++) begin
                if (wr_en_i[l] && (wr_addr_i[l] != '0)) begin
                    regs[wr_addr_i[l]] <= wr_data_i[l];
                end
            end
        end
    end

endmodule

//--- src/issue_execute.sv
`timescale 1ns/1ps

module issue_execute import rv_core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       stall_i,
    bundle_if.consumer in,
    output reg_idx_t   rs_addr_o [2*NUM_LANES],
    input  word_t      rs_data_i [2*NUM_LANES],
    output logic       wr_en_o [NUM_LANES],
    output reg_idx_t   wr_addr_o [NUM_LANES],
    output word_t      wr_data_o [NUM_LANES],
    output logic       retire_valid_o,
    output logic       retire_we_o [NUM_LANES],
    output reg_idx_t   retire_rd_o [NUM_LANES],
    output word_t      retire_data_o [NUM_LANES],
    output word_t      retire_pc_o
);

    dec_op_t dec [NUM_LANES];
    word_t   op_a [NUM_LANES];
    word_t   op_b [NUM_LANES];
    word_t   result [NUM_LANES];
    logic    pop;

    function automatic word_t alu(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            default: return '0;
        endcase
    endfunction

    // Head leaves in any unstalled cycle
    assign pop     = in.valid && !stall_i;
    assign in.pop  = pop;

    // ==============================
    // Decode and register access
    // ==============================

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        lane_decoder u_dec (
            .instr_i (in.bundle.instr[g]),
            .op_o    (dec[g])
        );
        assign rs_addr_o[2*g]   = dec[g].rs1;
        assign rs_addr_o[2*g+1] = dec[g].rs2;
        // Writes only on the pop edge
        assign wr_en_o[g]   = pop && dec[g].we;
        assign wr_addr_o[g] = dec[g].rd;
        assign wr_data_o[g] = result[g];
    end

    // Highest matching lower lane forwards its result
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            op_a[i] = rs_data_i[2*i];
            op_b[i] = rs_data_i[2*i+1];
            for (int j = 0; j < i; j++) begin
                if (dec[j].we && (dec[j].rd == dec[i].rs1)) begin
                    op_a[i] = result[j];
                end
                if (dec[j].we && (dec[j].rd == dec[i].rs2)) begin
                    op_b[i] = result[j];
                end
            end
            // Sign-extend the 12-bit immediate
            if (dec[i].use_imm) begin
                op_b[i] = {{(XLEN-IMM_W){dec[i].imm[IMM_W-1]}}, dec[i].imm};
            end
            result[i] = alu(dec[i].alu_op, op_a[i], op_b[i]);
        end
    end

    // ==============================
    // Retire registers
    // ==============================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            retire_valid_o <= 1'b0;
            for (int i = 0; i < NUM_LANES; i++) begin
                retire_we_o[i] <= 1'b0;
            end
        end else begin
            retire_valid_o <= pop;
            for (int i = 0; i < NUM_LANES; i++) begin
                retire_we_o[i] <= pop && dec[i].we;
            end
        end
    end

    // Retired payload holds between pops
    always_ff @(posedge clk) begin
        if (pop) begin
            retire_pc_o <= in.bundle.pc;
            for (int i = 0; i < NUM_LANES; i++) begin
                retire_rd_o[i]   <= dec[i].rd;
                retire_data_o[i] <= result[i];
            end
        end
    end

endmodule

//--- src/lane_decoder.sv
`timescale 1ns/1ps

module lane_decoder import rv_core_pkg::*; (
    input  word_t   instr_i,
    output dec_op_t op_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_e    op;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // ==============================
    // Operation select
    // ==============================

    always_comb begin
        op = ALU_NOP;
        if (opcode == OPC_OP) begin
            // Register form, funct7 must match exactly
            case (funct3)
                F3_ADD_SUB: begin
                    if (funct7 == F7_BASE) begin
                        op = ALU_ADD;
                    end else if (funct7 == F7_SUB) begin
                        op = ALU_SUB;
                    end
                end
                F3_XOR:  op = (funct7 == F7_BASE) ? ALU_XOR : ALU_NOP;
                F3_OR:   op = (funct7 == F7_BASE) ? ALU_OR  : ALU_NOP;
                F3_AND:  op = (funct7 == F7_BASE) ? ALU_AND : ALU_NOP;
                default: op = ALU_NOP;
            endcase
        end else if (opcode == OPC_OP_IMM) begin
            // Immediate form, upper bits belong to imm
            case (funct3)
                F3_ADD_SUB: op = ALU_ADD;
                F3_XOR:     op = ALU_XOR;
                F3_OR:      op = ALU_OR;
                F3_AND:     op = ALU_AND;
                default:    op = ALU_NOP;
            endcase
        end
    end

    // Field extraction
    assign op_o.rs1     = instr_i[19:15];
    assign op_o.rs2     = (opcode == OPC_OP) ? instr_i[24:20] : '0;
    assign op_o.rd      = instr_i[11:7];
    assign op_o.use_imm = (opcode == OPC_OP_IMM);
    // No write for no-ops or for x0
    assign op_o.we      = (op != ALU_NOP) && (instr_i[11:7] != '0);
    assign op_o.alu_op  = op;
    assign op_o.imm     = instr_i[31:20];

endmodule

//--- src/inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer import rv_core_pkg::*; #(
    parameter int BUFFER_DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    bundle_if.consumer                    in,
    bundle_if.producer                    out,
    output logic [$clog2(BUFFER_DEPTH):0] occupancy_o
);

    localparam int PTR_W = $clog2(BUFFER_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    // ==============================
    // Storage and pointers
    // ==============================

    bundle_t    mem [BUFFER_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    assign full = (count == CNT_W'(BUFFER_DEPTH));

    // Push only with room, pop only with data
    assign push = in.valid && !full;
    assign pop  = out.pop && (count != '0);

    // Fetch side status
    assign in.full = full;
    // Accept strobe back to fetch side
    assign in.pop  = push;

    // Head is visible straight from storage
    assign out.valid  = (count != '0);
    assign out.bundle = mem[rd_ptr];

    assign occupancy_o = count;

    // Payload storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in.bundle;
        end
    end

    // Pointers wrap on power-of-two depth
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop keeps the count
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import rv_core_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    output word_t       inst_addr_o [NUM_LANES],
    input  word_t       inst_data_i [NUM_LANES],
    bundle_if.producer  out
);

    // Bytes covered by one fetch group
    localparam word_t BUNDLE_BYTES = word_t'(4 * NUM_LANES);

    word_t   pc;
    logic    push;
    bundle_t fetched;

    // Push whenever the buffer has room
    assign push = !out.full;

    // Consecutive word addresses from the current pc
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            inst_addr_o[i] = pc + word_t'(4 * i);
        end
    end

    // Pack returned words with the group pc
    always_comb begin
        fetched.pc = pc;
        for (int i = 0; i < NUM_LANES; i++) begin
            fetched.instr[i] = inst_data_i[i];
        end
    end

    assign out.valid  = push;
    assign out.bundle = fetched;

    // Pc holds while the buffer is full
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= '0;
        end else if (push) begin
            pc <= pc + BUNDLE_BYTES;
        end
    end

endmodule

//--- src/bundle_if.sv
`timescale 1ns/1ps

interface bundle_if import rv_core_pkg::*; ();

    // Push strobe or not-empty, depending on the link
    logic    valid;
    bundle_t bundle;
    // Accept strobe from the receiving side
    logic    pop;
    // Receiving side cannot take a bundle
    logic    full;

    modport producer (
        output valid,
        output bundle,
        input  pop,
        input  full
    );

    modport consumer (
        input  valid,
        input  bundle,
        output pop,
        output full
    );

endinterface

//--- src/rv_core_pkg.sv
package rv_core_pkg;

    // ==============================
    // Core widths
    // ==============================

    localparam int XLEN       = 32;
    localparam int NUM_LANES  = 3;
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 12;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    // Fetch group, lane 0 word in the low slot
    typedef struct packed {
        word_t                 pc;
        word_t [NUM_LANES-1:0] instr;
    } bundle_t;

    // ==============================
    // RV32I encodings
    // ==============================

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_NOP = 3'd7
    } alu_op_e;

    // One decoded lane, immediate kept narrow until the ALU
    typedef struct packed {
        reg_idx_t         rs1;
        reg_idx_t         rs2;
        reg_idx_t         rd;
        logic             use_imm;
        logic             we;
        alu_op_e          alu_op;
        logic [IMM_W-1:0] imm;
    } dec_op_t;

endpackage
